//--- build.sh
#!/usr/bin/env bash
# Compile the fill accelerator testbench with Verilator and run it
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/1ps \
	--top-module tb_fill_wrapper \
	-f fill_accel.f \
	-o tb_fill_wrapper

./obj_dir/tb_fill_wrapper | tee sim.log

# The testbench prints its verdict as a line of its own
if grep -qx "all tests passed" sim.log; then
	echo "simulation PASS"
else
	echo "simulation FAIL, see sim.log"
	exit 1
fi

//--- fill_accel.f
src/fill_pkg.sv
src/fill_ctrl.sv
src/scanline_filler.sv
src/pixel_writer.sv
src/fill_wrapper.sv
sim/tb_fill_wrapper.sv

//--- sim/tb_fill_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fill_wrapper;
	import fill_pkg::*;

	localparam int N_CMD = 7;

	typedef struct packed {
		fill_cmd_t cmd;
		logic      fixed; // Reference outline rows instead of random ones
		logic      b2b;   // Issue as soon as busy falls
		logic      poke;  // Extra fill_en while busy that must be dropped
	} entry_t;

	typedef struct packed {
		logic [31:0] at;    // Rising edge that samples this write
		pix_addr_t   addr;
		row_bits_t   en;
		color_t      color;
	} exp_wr_t;

	logic        clk;
	logic        rst_n;
	logic        fill_en;
	fill_cmd_t   cmd;
	line_buf_t   line_buffer;
	logic        busy;
	logic        mem_we;
	mem_wr_t     mem_wr;
	logic        done;

	entry_t      cmd_table [N_CMD];
	exp_wr_t     wq[$];          // Expected writes in order
	logic [31:0] dq[$];          // Expected done edges
	logic [31:0] cyc = 32'd0;    // Rising edges so far
	logic [31:0] limit;          // Timeout in cycles
	logic [31:0] rng;
	int          err_val;        // Wrong values
	int          err_misc;       // Anything else
	int          n_wr;
	int          n_exp;

	fill_wrapper fill_wrapper_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.fill_en     (fill_en),
		.cmd         (cmd),
		.line_buffer (line_buffer),
		.busy        (busy),
		.mem_we      (mem_we),
		.mem_wr      (mem_wr),
		.done        (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	always @(posedge clk)
	begin
		cyc <= cyc + 32'd1;
		if (cyc >= limit)
		begin
			$display("timeout after %0d cycles, expected writes or done never arrived", cyc);
			$display("tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Pixels along one axis after the clip
	function automatic int extent(input coord_t first, input coord_t last);
		int d;
		if (last < first)
			return 1; // Reversed axis gives one row or column
		d = int'(last) - int'(first);
		return (d > WIN - 1) ? WIN : d + 1;
	endfunction

	// Parity rule over the first cols columns
	function automatic row_bits_t fill_row(input row_bits_t outline, input int cols);
		row_bits_t m;
		int        left; // Outline pixels strictly left of c
		m    = '0;
		left = 0;
		for (int c = 0; c < cols; c++)
		begin
			if (outline[c] || (left % 2 == 1))
				m[c] = 1'b1;
			if (outline[c])
				left++;
		end
		return m;
	endfunction

	task automatic check_addr(input string name, input pix_addr_t got, input pix_addr_t exp);
		if (got !== exp)
		begin
			err_val++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bits(input string name, input row_bits_t got, input row_bits_t exp);
		if (got !== exp)
		begin
			err_val++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_color(input string name, input color_t got, input color_t exp);
		if (got !== exp)
		begin
			err_val++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			err_val++;
			$display("[ERROR] %s got %h expected %h at cycle %0d", name, got, exp, cyc);
		end
	endtask

	task automatic set_entry(input int i, input int xs, input int ys, input int xe,
		input int ye, input color_t col, input logic layer, input logic fixed,
		input logic b2b, input logic poke);
		cmd_table[i].cmd.x_start = coord_t'(xs);
		cmd_table[i].cmd.y_start = coord_t'(ys);
		cmd_table[i].cmd.x_end   = coord_t'(xe);
		cmd_table[i].cmd.y_end   = coord_t'(ye);
		cmd_table[i].cmd.color   = col;
		cmd_table[i].cmd.layer   = layer;
		cmd_table[i].fixed       = fixed;
		cmd_table[i].b2b         = b2b;
		cmd_table[i].poke        = poke;
	endtask

	task automatic make_bitmap(input logic fixed, output line_buf_t lb);
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] w2;
		logic [31:0] w3;
		lb = '0;
		if (fixed)
		begin
			lb[0*WIN +: WIN] = 64'h1;
			lb[1*WIN +: WIN] = 64'h3;
			lb[2*WIN +: WIN] = 64'h5;
			lb[3*WIN +: WIN] = 64'h9;
			lb[4*WIN +: WIN] = 64'h1f;
		end
		else
		begin
			for (int r = 0; r < WIN; r++)
			begin
				rng = xorshift32(rng);
				w0  = rng;
				rng = xorshift32(rng);
				w1  = rng;
				rng = xorshift32(rng);
				w2  = rng;
				rng = xorshift32(rng);
				w3  = rng;
				lb[r*WIN +: WIN] = {w0 & w1, w2 & w3}; // About one pixel in four
			end
		end
	endtask

	// Queue every row write and the done of one accepted command
	task automatic expect_command(input fill_cmd_t c, input line_buf_t lb,
		input logic [31:0] acc);
		int      rows;
		int      cols;
		exp_wr_t e;
		rows = extent(c.y_start, c.y_end);
		cols = extent(c.x_start, c.x_end);
		for (int r = 0; r < rows; r++)
		begin
			e.at    = acc + 32'(3 + r); // Pipeline of three stages
			e.addr  = {c.layer, coord_t'(c.y_start + coord_t'(r)), c.x_start};
			e.en    = fill_row(lb[r*WIN +: WIN], cols);
			e.color = c.color;
			wq.push_back(e);
		end
		dq.push_back(acc + 32'(rows + 3));
		n_exp += rows;
	endtask

	task automatic wait_drained();
		while (wq.size() > 0 || dq.size() > 0)
			@(negedge clk);
	endtask

	// Mid-cycle compare against the head of each queue
	always @(negedge clk)
	begin
		exp_wr_t e;
		logic    want_we;
		logic    want_done;
		if (rst_n)
		begin
			want_we = (wq.size() > 0) && (wq[0].at == cyc + 32'd1);
			check_flag("mem_we", mem_we, want_we);
			if (want_we)
			begin
				e = wq.pop_front();
				if (mem_we)
				begin
					n_wr++;
					check_addr("mem_wr.addr", mem_wr.addr, e.addr);
					check_bits("mem_wr.en", mem_wr.en, e.en);
					for (int p = 0; p < WIN; p++)
						check_color($sformatf("mem_wr.pix[%0d]", p), mem_wr.pix[p], e.color);
				end
			end
			want_done = (dq.size() > 0) && (dq[0] == cyc + 32'd1);
			check_flag("done", done, want_done);
			if (want_done)
				void'(dq.pop_front());
		end
	end

	initial
	begin
		line_buf_t lb;
		fill_en     = 1'b0;
		cmd         = '0;
		line_buffer = '0;
		rst_n       = 1'b0;
		err_val     = 0;
		err_misc    = 0;
		n_wr        = 0;
		n_exp       = 0;
		rng         = 32'h4c30;

		set_entry(0, 0, 0, 63, 63, 24'hff8000, 1'b0, 1'b1, 1'b0, 1'b0);       // Reference rows
		set_entry(1, 10, 20, 17, 25, 24'h00ff00, 1'b1, 1'b0, 1'b0, 1'b0);     // Small
		set_entry(2, 100, 5, 400, 300, 24'h1234ab, 1'b0, 1'b0, 1'b0, 1'b1);   // Clamped
		set_entry(3, 50, 60, 40, 70, 24'hc0ffee, 1'b1, 1'b0, 1'b0, 1'b0);     // x reversed
		set_entry(4, 0, 30, 5, 10, 24'h5a5a5a, 1'b0, 1'b0, 1'b1, 1'b0);       // y reversed
		set_entry(5, 200, 4000, 231, 4015, 24'h0000ff, 1'b1, 1'b0, 1'b1, 1'b0);
		set_entry(6, 7, 7, 7, 7, 24'hffffff, 1'b0, 1'b0, 1'b0, 1'b0);         // One pixel

		limit = 32'd20; // Reset and idle
		for (int i = 0; i < N_CMD; i++)
			limit = limit + 32'(extent(cmd_table[i].cmd.y_start, cmd_table[i].cmd.y_end) + 10);

		// Model against hand-worked rows
		if (fill_row(64'h3, WIN) !== 64'h3 || fill_row(64'h5, WIN) !== 64'h7 ||
			fill_row(64'h9, WIN) !== 64'hf || fill_row(64'h1, 4) !== 64'hf)
		begin
			err_misc++;
			$display("reference model disagrees with hand-worked fill rows");
		end

		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		repeat (5)
		begin
			@(negedge clk);
			check_flag("busy", busy, 1'b0); // Idle before the first command
		end

		for (int i = 0; i < N_CMD; i++)
		begin
			make_bitmap(cmd_table[i].fixed, lb);
			if (!cmd_table[i].b2b)
				wait_drained();
			@(negedge clk);
			while (busy)
				@(negedge clk); // b2b lands in the first idle cycle
			fill_en     = 1'b1;
			cmd         = cmd_table[i].cmd;
			line_buffer = lb;
			expect_command(cmd_table[i].cmd, lb, cyc + 32'd1);
			@(negedge clk);
			fill_en     = 1'b0;
			cmd         = '0;
			line_buffer = '0;
			check_flag("busy", busy, 1'b1); // Controller holds the accepted command
			if (cmd_table[i].poke)
			begin
				@(negedge clk);
				fill_en     = 1'b1; // Dropped by the busy controller
				cmd         = cmd_table[6].cmd;
				line_buffer = ~lb;
				@(negedge clk);
				fill_en     = 1'b0;
				cmd         = '0;
				line_buffer = '0;
			end
		end

		wait_drained();
		repeat (3) @(negedge clk); // Room for stray writes
		if (n_wr != n_exp)
		begin
			err_misc++;
			$display("saw %0d row writes where %0d were due", n_wr, n_exp);
		end

		$display("closing: %0d writes, %0d value errors, %0d other errors",
			n_wr, err_val, err_misc);
		if (err_val == 0 && err_misc == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/fill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fill_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                fill_en,
	input  fill_pkg::fill_cmd_t cmd,
	input  fill_pkg::line_buf_t line_buffer,
	output logic                busy,
	output logic                req_valid,
	output fill_pkg::row_req_t  req
);
	import fill_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	win_idx_t    row_cnt;  // Row being issued
	win_idx_t    row_last; // Clipped row extent minus one
	win_idx_t    col_last; // Clipped column extent minus one
	fill_cmd_t   cmd_q;
	line_buf_t   rows_q;   // Bitmap shifted down one row per issue
	logic        accept;
	logic        final_row;

	// Extent minus one clamped to the window and zero when reversed
	function automatic win_idx_t clip_last(input coord_t first, input coord_t last);
		coord_t diff;
		diff = last - first;
		if (last < first)
			return '0; // Reversed axis gives a single row or column
		else if (diff > coord_t'(WIN - 1))
			return win_idx_t'(WIN - 1);
		else
			return diff[ROW_W-1:0];
	endfunction

	assign accept    = fill_en && (state == IDLE); // fill_en while busy dropped
	assign final_row = (row_cnt == row_last);

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
				if (accept)
					state_nxt = ISSUE;
			ISSUE:
				if (final_row)
					state_nxt = IDLE; // Free for the next command
			default:
				state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= IDLE;
			row_cnt <= '0;
		end
		else
		begin
			state <= state_nxt;
			if (accept)
				row_cnt <= '0;
			else if (state == ISSUE)
				row_cnt <= row_cnt + 1'b1; // Steps once past the final row as ISSUE ends
		end
	end

	// Command and bitmap captured only on acceptance
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			cmd_q    <= cmd;
			rows_q   <= line_buffer;
			row_last <= clip_last(cmd.y_start, cmd.y_end);
			col_last <= clip_last(cmd.x_start, cmd.x_end);
		end
		else if (state == ISSUE)
			rows_q <= rows_q >> WIN; // Next row moves to the bottom
	end

	// One row per cycle while issuing
	assign busy      = (state == ISSUE);
	assign req_valid = (state == ISSUE);

	always_comb
	begin
		req.row_bits = rows_q[WIN-1:0];
		req.col_last = col_last;
		req.y        = cmd_q.y_start + coord_t'(row_cnt); // Absolute screen row
		req.x_start  = cmd_q.x_start;
		req.color    = cmd_q.color;
		req.layer    = cmd_q.layer;
		req.last     = final_row;
	end

	// A row stream only starts right after an accepted command
	a_req_starts_on_accept: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(req_valid) |-> $past(accept));

	// Row counter stays inside the clipped extent
	a_row_in_extent: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid |-> (row_cnt <= row_last));

endmodule

`default_nettype wire

//--- src/fill_pkg.sv
`default_nettype none

package fill_pkg;

	localparam int WIN     = 64; // Window edge, also pixels per row write
	localparam int COORD_W = 12; // Screen coordinate
	localparam int COLOR_W = 24; // RGB, 8 bits per channel
	localparam int ROW_W   = 6;  // Index inside the window
	localparam int ADDR_W  = 1 + 2 * COORD_W; // Layer, y, x

	typedef logic [COORD_W-1:0]   coord_t;
	typedef logic [COLOR_W-1:0]   color_t;
	typedef logic [ROW_W-1:0]     win_idx_t;
	typedef logic [WIN-1:0]       row_bits_t; // One row of outline or mask bits
	typedef logic [ADDR_W-1:0]    pix_addr_t;
	typedef logic [WIN*WIN-1:0]   line_buf_t; // Row r at bits 64r +: 64

	// Fill command as it arrives with fill_en
	typedef struct packed {
		coord_t x_start;
		coord_t y_start;
		coord_t x_end;
		coord_t y_end;
		color_t color;
		logic   layer;
	} fill_cmd_t;

	// One row request from the controller
	typedef struct packed {
		row_bits_t row_bits; // Outline pixels of this row
		win_idx_t  col_last; // Last column inside the clip
		coord_t    y;        // Absolute row
		coord_t    x_start;
		color_t    color;
		logic      layer;
		logic      last;     // Final row of the command
	} row_req_t;

	// Same row after the parity fill
	typedef struct packed {
		row_bits_t mask;
		win_idx_t  col_last;
		coord_t    y;
		coord_t    x_start;
		color_t    color;
		logic      layer;
		logic      last;
	} row_span_t;

	// Wide row write to the frame memory
	typedef struct packed {
		pix_addr_t         addr;
		row_bits_t         en;  // Per-pixel write enable
		color_t [WIN-1:0]  pix; // Pixel c in slot c
	} mem_wr_t;

	typedef enum logic {
		IDLE,
		ISSUE
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- src/fill_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module fill_wrapper (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                fill_en,
	input  fill_pkg::fill_cmd_t cmd,
	input  fill_pkg::line_buf_t line_buffer,
	output logic                busy,
	output logic                mem_we,
	output fill_pkg::mem_wr_t   mem_wr,
	output logic                done
);
	import fill_pkg::*;

	logic      req_valid;
	row_req_t  req;        // Controller to filler
	logic      span_valid;
	row_span_t span;       // Filler to writer

	// Command intake and row walk
	fill_ctrl fill_ctrl_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.fill_en     (fill_en),
		.cmd         (cmd),
		.line_buffer (line_buffer),
		.busy        (busy),
		.req_valid   (req_valid),
		.req         (req)
	);

	// Parity fill per row
	scanline_filler scanline_filler_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req        (req),
		.span_valid (span_valid),
		.span       (span)
	);

	// Frame memory write and completion
	pixel_writer pixel_writer_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.span_valid (span_valid),
		.span       (span),
		.mem_we     (mem_we),
		.mem_wr     (mem_wr),
		.done       (done)
	);

endmodule

`default_nettype wire

//--- src/pixel_writer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_writer (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                span_valid,
	input  fill_pkg::row_span_t span,
	output logic                mem_we,
	output fill_pkg::mem_wr_t   mem_wr,
	output logic                done
);
	import fill_pkg::*;

	mem_wr_t wr_nxt;
	logic    last_q; // Write on the bus closes its command

	always_comb
	begin
		wr_nxt.addr = {span.layer, span.y, span.x_start}; // Layer, row, left edge
		wr_nxt.en   = span.mask;
		// Flat fill puts the command colour in every slot
		for (int p = 0; p < WIN; p++)
			wr_nxt.pix[p] = span.color;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mem_we <= 1'b0;
			last_q <= 1'b0;
			done   <= 1'b0;
		end
		else
		begin
			mem_we <= span_valid;
			last_q <= span_valid && span.last;
			done   <= mem_we && last_q; // One cycle after the final write
		end
	end

	// Write payload held for the memory
	always_ff @(posedge clk)
	begin
		if (span_valid)
			mem_wr <= wr_nxt;
	end

	// Never overlaps the last write it reports
	a_done_not_with_last: assert property (@(posedge clk) disable iff (!rst_n)
		!(done && mem_we && last_q));

endmodule

`default_nettype wire

//--- src/scanline_filler.sv
`timescale 1ns/1ps
`default_nettype none

module scanline_filler (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                req_valid,
	input  fill_pkg::row_req_t  req,
	output logic                span_valid,
	output fill_pkg::row_span_t span
);
	import fill_pkg::*;

	row_bits_t in_range;  // Columns 0 to col_last
	row_bits_t outline;   // Outline after the column clip
	row_bits_t fill_mask;
	logic      parity;    // Running xor of outline bits to the left

	// Ones from column 0 through last
	function automatic row_bits_t range_mask(input win_idx_t last);
		row_bits_t m;
		for (int c = 0; c < WIN; c++)
			m[c] = (c <= int'(last));
		return m;
	endfunction

	always_comb
	begin
		in_range = range_mask(req.col_last);
		outline  = req.row_bits & in_range; // Pixels past the clip do not count
		parity   = 1'b0;
		for (int c = 0; c < WIN; c++)
		begin
			// Inside if on the outline or an odd count lies to the left
			fill_mask[c] = (outline[c] | parity) & in_range[c];
			parity       = parity ^ outline[c];
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			span_valid <= 1'b0;
		else
			span_valid <= req_valid; // One cycle of latency
	end

	// Span payload meaningful only with span_valid
	always_ff @(posedge clk)
	begin
		if (req_valid)
		begin
			span.mask     <= fill_mask;
			span.col_last <= req.col_last;
			span.y        <= req.y;
			span.x_start  <= req.x_start;
			span.color    <= req.color;
			span.layer    <= req.layer;
			span.last     <= req.last;
		end
	end

	// Nothing written outside the clipped columns
	a_mask_in_clip: assert property (@(posedge clk) disable iff (!rst_n)
		span_valid |-> ((span.mask & ~range_mask(span.col_last)) == '0));

endmodule

`default_nettype wire
